//--- design/pipe_ctrl_cfg.svh
`ifndef PIPE_CTRL_CFG_SVH
`define PIPE_CTRL_CFG_SVH

// graduation list has 32 entries
`define PC_GL_INDEX_W 5

// four rename checkpoints
`define PC_CHKP_W 2

// scalar write-back ports into the register file
`define PC_NUM_WB 2

`endif

//--- design/pipe_ctrl_pkg.sv
`include "pipe_ctrl_cfg.svh"

package pipe_ctrl_pkg;

    // graduation list entry index
    typedef logic [`PC_GL_INDEX_W-1:0] gl_index_t;

    // rename checkpoint id
    typedef logic [`PC_CHKP_W-1:0] chkp_t;

    // one bit per write-back port
    typedef logic [`PC_NUM_WB-1:0] wb_vec_t;

    // source of the next fetch pc
    typedef enum logic [1:0] {
        NEXT_PC_SEL_BP_OR_PC_4 = 2'd0,
        NEXT_PC_SEL_KEEP_PC    = 2'd1,
        NEXT_PC_SEL_JUMP       = 2'd2,
        NEXT_PC_SEL_DEBUG      = 2'd3
    } next_pc_sel_t;

    // which jump address fetch takes
    typedef enum logic [2:0] {
        SEL_JUMP_DECODE    = 3'd0,
        SEL_JUMP_EXECUTION = 3'd1,
        SEL_JUMP_CSR       = 3'd2,
        SEL_JUMP_CSR_RW    = 3'd3,
        SEL_JUMP_DEBUG     = 3'd4
    } sel_addr_if_t;

    // one-shot redirect after exception or csr fence commit
    typedef enum logic [1:0] {
        RDR_IDLE = 2'd0,
        RDR_XCPT = 2'd1,
        RDR_CSR  = 2'd2
    } redirect_state_t;

endpackage

//--- design/ctrl_event_if.sv
`timescale 1ns/1ps

interface ctrl_event_if (
    input logic clk_i,
    input logic rstn_i
);

    logic mispredict;
    logic bad_pred;
    logic jal;
    logic xcpt_trigger;
    // registered one-cycle redirects
    logic rdr_xcpt;
    logic rdr_csr;
    // csr fence somewhere between decode and commit
    logic fence_hold;
    logic commit_fence;
    logic commit_csr_fence;

    modport decode_mp (
        output mispredict, bad_pred, jal, xcpt_trigger, rdr_xcpt, rdr_csr,
        output fence_hold, commit_fence, commit_csr_fence
    );

    modport resolve_mp (
        input clk_i, rstn_i,
        input mispredict, bad_pred, jal, rdr_xcpt, rdr_csr,
        input fence_hold, commit_fence, commit_csr_fence
    );

    modport result_mp (
        input clk_i, rstn_i,
        input mispredict, bad_pred, jal, xcpt_trigger, rdr_xcpt, rdr_csr,
        input fence_hold, commit_fence, commit_csr_fence
    );

endinterface

//--- design/ctrl_event_decode.sv
`timescale 1ns/1ps

module ctrl_event_decode (
    input  logic clk_i,
    input  logic rstn_i,
    input  logic id_valid_i,
    input  logic id_is_branch_i,
    input  logic id_pred_branch_i,
    input  logic id_jal_i,
    input  logic id_csr_fence_i,
    input  logic exe_valid_i,
    input  logic branch_correct_i,
    input  logic commit_valid_i,
    input  logic commit_xcpt_i,
    input  logic commit_ecall_i,
    input  logic commit_fence_i,
    input  logic commit_csr_fence_i,
    input  logic csr_eret_i,
    input  logic csr_exception_i,
    ctrl_event_if.decode_mp ev
);

    import pipe_ctrl_pkg::*;

    redirect_state_t rdr_state_q;
    redirect_state_t rdr_state_d;
    logic            fence_in_flight;
    logic            id_csr_fence;

    assign id_csr_fence = id_valid_i & id_csr_fence_i;

    // events formed once here, other blocks only read them
    assign ev.mispredict       = exe_valid_i & ~branch_correct_i;
    assign ev.bad_pred         = id_valid_i & ~id_is_branch_i & id_pred_branch_i;
    assign ev.jal              = id_valid_i & id_jal_i;
    assign ev.commit_fence     = commit_valid_i & commit_fence_i;
    assign ev.commit_csr_fence = commit_valid_i & commit_csr_fence_i;
    assign ev.xcpt_trigger     = (commit_valid_i & (commit_xcpt_i | commit_ecall_i)) |
                                 csr_eret_i | csr_exception_i;

    assign ev.fence_hold = id_csr_fence | fence_in_flight | ev.commit_csr_fence;

    // a redirect lasts one cycle, then the machine goes back to idle
    always_comb begin
        rdr_state_d = RDR_IDLE;
        if (rdr_state_q == RDR_IDLE) begin
            if (ev.xcpt_trigger) begin
                rdr_state_d = RDR_XCPT;
            end else if (ev.commit_csr_fence) begin
                rdr_state_d = RDR_CSR;
            end
        end
    end

    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            rdr_state_q <= RDR_IDLE;
        end else begin
            rdr_state_q <= rdr_state_d;
        end
    end

    assign ev.rdr_xcpt = (rdr_state_q == RDR_XCPT);
    assign ev.rdr_csr  = (rdr_state_q == RDR_CSR);

    // fence in flight; pipeline flushes kill the fence before its commit
    always_ff @(posedge clk_i or negedge rstn_i) begin
        if (!rstn_i) begin
            fence_in_flight <= 1'b0;
        end else if (ev.rdr_xcpt || ev.mispredict) begin
            fence_in_flight <= 1'b0;
        end else if (id_csr_fence) begin
            fence_in_flight <= 1'b1;
        end else if (ev.commit_csr_fence) begin
            fence_in_flight <= 1'b0;
        end
    end

    // an exception redirect always kills a pending fence
    a_no_fence_after_xcpt: assert property (
        @(posedge clk_i) disable iff (!rstn_i)
        ev.rdr_xcpt |=> !fence_in_flight
    );

endmodule

//--- design/ctrl_hazard_resolve.sv
`timescale 1ns/1ps

module ctrl_hazard_resolve (
    ctrl_event_if.resolve_mp ev,
    input  logic csr_stall_i,
    input  logic iq_full_i,
    input  logic icache_miss_i,
    input  logic icache_ready_i,
    input  logic exe_stall_i,
    input  logic gl_full_i,
    input  logic free_list_empty_i,
    input  logic out_of_chkp_i,
    output logic stall_if1_o,
    output logic stall_if2_o,
    output logic stall_id_o,
    output logic stall_ir_o,
    output logic stall_rr_o,
    output logic stall_exe_o,
    output logic flush_if_o,
    output logic flush_id_o,
    output logic flush_ir_o,
    output logic flush_rr_o,
    output logic flush_exe_o
);

    // front end stalls
    always_comb begin
        stall_if1_o = 1'b0;
        stall_if2_o = 1'b0;
        stall_id_o  = 1'b0;
        if (csr_stall_i || iq_full_i) begin
            stall_if1_o = 1'b1;
            stall_if2_o = 1'b1;
            stall_id_o  = 1'b1;
        end else if (ev.commit_csr_fence || icache_miss_i || !icache_ready_i) begin
            // only the fetch request waits
            stall_if1_o = 1'b1;
        end
    end

    // back end stalls
    always_comb begin
        stall_ir_o  = 1'b0;
        stall_rr_o  = 1'b0;
        stall_exe_o = 1'b0;
        if (csr_stall_i) begin
            stall_ir_o  = 1'b1;
            stall_rr_o  = 1'b1;
            stall_exe_o = 1'b1;
        end else if (exe_stall_i || gl_full_i) begin
            stall_ir_o = 1'b1;
            stall_rr_o = 1'b1;
        end else if (free_list_empty_i || out_of_chkp_i) begin
            stall_ir_o = 1'b1;
        end
    end

    // front end flushes
    always_comb begin
        flush_if_o = 1'b0;
        flush_id_o = 1'b0;
        if (ev.rdr_xcpt || ev.rdr_csr || ev.mispredict) begin
            flush_if_o = 1'b1;
            flush_id_o = 1'b1;
        end else if (!csr_stall_i &&
                     (ev.fence_hold || ev.jal || ev.commit_fence || ev.bad_pred)) begin
            // decode keeps its instruction, only the wrong fetch is dropped
            flush_if_o = 1'b1;
        end
    end

    // back end flushes
    always_comb begin
        flush_ir_o  = 1'b0;
        flush_rr_o  = 1'b0;
        flush_exe_o = 1'b0;
        if (ev.rdr_xcpt) begin
            flush_ir_o  = 1'b1;
            flush_rr_o  = 1'b1;
            flush_exe_o = 1'b1;
        end else if (ev.mispredict) begin
            flush_ir_o = 1'b1;
            // a stalled rr still holds older work
            flush_rr_o = !exe_stall_i;
        end else if (gl_full_i) begin
            flush_rr_o = 1'b1;
        end
    end

    a_exe_flush_covers_ir: assert property (
        @(posedge ev.clk_i) disable iff (!ev.rstn_i)
        flush_exe_o |-> flush_ir_o
    );

endmodule

//--- design/ctrl_redirect_result.sv
`timescale 1ns/1ps

module ctrl_redirect_result (
    ctrl_event_if.result_mp ev,
    input  logic                      stall_if1_i,
    input  logic                      stall_ir_i,
    input  logic                      flush_ir_i,
    input  logic                      debug_halt_i,
    input  logic                      debug_change_pc_i,
    input  logic                      debug_wr_valid_i,
    input  logic                      ir_valid_i,
    input  logic                      ir_is_branch_i,
    input  logic                      exe_valid_i,
    input  logic                      branch_correct_i,
    input  logic                      exe_chkp_done_i,
    input  logic                      commit_valid_i,
    input  logic                      commit_xcpt_i,
    input  logic                      commit_we_i,
    input  logic                      commit_regfile_we_i,
    input  logic                      commit_stall_i,
    input  logic                      commit_fence_i_i,
    input  logic                      csr_exception_i,
    input  logic                      out_of_chkp_i,
    input  pipe_ctrl_pkg::chkp_t      exe_chkp_i,
    input  pipe_ctrl_pkg::gl_index_t  exe_gl_index_i,
    input  pipe_ctrl_pkg::wb_vec_t    wb_valid_i,
    input  pipe_ctrl_pkg::wb_vec_t    wb_we_i,
    output pipe_ctrl_pkg::next_pc_sel_t next_pc_sel_o,
    output pipe_ctrl_pkg::sel_addr_if_t sel_addr_if_o,
    output logic                      invalidate_icache_o,
    output logic                      invalidate_buffer_o,
    output logic                      do_checkpoint_o,
    output logic                      do_recover_o,
    output logic                      delete_checkpoint_o,
    output logic                      enable_commit_update_o,
    output logic                      recover_commit_o,
    output logic                      flush_gl_o,
    output logic                      flush_gl_commit_o,
    output logic                      enable_commit_o,
    output logic                      rf_we_dbg_o,
    output pipe_ctrl_pkg::chkp_t      recover_chkp_o,
    output pipe_ctrl_pkg::gl_index_t  flush_gl_index_o,
    output pipe_ctrl_pkg::wb_vec_t    rf_we_o
);

    import pipe_ctrl_pkg::*;

    logic debug_jump;

    assign debug_jump = debug_halt_i & debug_change_pc_i;

    always_comb begin
        if (debug_jump) begin
            next_pc_sel_o = NEXT_PC_SEL_DEBUG;
        end else if (ev.mispredict || ev.bad_pred || ev.jal || ev.rdr_xcpt || ev.rdr_csr) begin
            next_pc_sel_o = NEXT_PC_SEL_JUMP;
        end else if (stall_if1_i || ev.fence_hold || ev.commit_fence || debug_halt_i) begin
            next_pc_sel_o = NEXT_PC_SEL_KEEP_PC;
        end else begin
            next_pc_sel_o = NEXT_PC_SEL_BP_OR_PC_4;
        end
    end

    // trap vector first, then csr restart pc, then branch target
    always_comb begin
        if (ev.rdr_xcpt) begin
            sel_addr_if_o = SEL_JUMP_CSR;
        end else if (ev.rdr_csr) begin
            sel_addr_if_o = SEL_JUMP_CSR_RW;
        end else if (ev.mispredict) begin
            sel_addr_if_o = SEL_JUMP_EXECUTION;
        end else if (debug_jump) begin
            sel_addr_if_o = SEL_JUMP_DEBUG;
        end else begin
            sel_addr_if_o = SEL_JUMP_DECODE;
        end
    end

    // rename checkpoints
    assign do_checkpoint_o     = ir_valid_i & ir_is_branch_i & ~out_of_chkp_i &
                                 ~stall_ir_i & ~flush_ir_i;
    assign do_recover_o        = ev.mispredict & exe_chkp_done_i;
    assign delete_checkpoint_o = exe_valid_i & branch_correct_i & exe_chkp_done_i;
    assign recover_chkp_o      = exe_chkp_i;

    // graduation list
    assign flush_gl_o        = ev.mispredict;
    assign flush_gl_index_o  = ev.mispredict ? exe_gl_index_i : '0;
    assign flush_gl_commit_o = ev.rdr_xcpt;
    assign recover_commit_o  = ev.rdr_xcpt;

    assign enable_commit_o        = ~commit_stall_i & ~ev.xcpt_trigger;
    assign enable_commit_update_o = commit_valid_i & commit_regfile_we_i & enable_commit_o;

    // port 0 is shared between commit and write-back
    always_comb begin
        rf_we_o = wb_valid_i & wb_we_i;
        if (commit_valid_i && commit_we_i && !commit_xcpt_i && !csr_exception_i) begin
            rf_we_o[0] = 1'b1;
        end
    end

    // debugger writes only while halted
    assign rf_we_dbg_o = debug_wr_valid_i & debug_halt_i;

    // fence.i may follow self-modifying code
    assign invalidate_icache_o = commit_valid_i & commit_fence_i_i;
    assign invalidate_buffer_o = (commit_valid_i & (commit_fence_i_i | ev.rdr_xcpt)) |
                                 (ev.commit_csr_fence & ~ev.commit_fence);

    a_recover_xor_delete: assert property (
        @(posedge ev.clk_i) disable iff (!ev.rstn_i)
        !(do_recover_o && delete_checkpoint_o)
    );

endmodule

//--- design/pipe_ctrl_top.sv
`timescale 1ns/1ps

module pipe_ctrl_top (
    input  logic                        clk_i,
    input  logic                        rstn_i,
    // decode
    input  logic                        id_valid_i,
    input  logic                        id_is_branch_i,
    input  logic                        id_pred_branch_i,
    input  logic                        id_jal_i,
    input  logic                        id_csr_fence_i,
    // rename and register read
    input  logic                        ir_valid_i,
    input  logic                        ir_is_branch_i,
    input  logic                        iq_full_i,
    input  logic                        free_list_empty_i,
    input  logic                        out_of_chkp_i,
    input  logic                        gl_full_i,
    // execute
    input  logic                        exe_valid_i,
    input  logic                        branch_correct_i,
    input  logic                        exe_stall_i,
    input  logic                        exe_chkp_done_i,
    input  pipe_ctrl_pkg::chkp_t        exe_chkp_i,
    input  pipe_ctrl_pkg::gl_index_t    exe_gl_index_i,
    // write-back
    input  pipe_ctrl_pkg::wb_vec_t      wb_valid_i,
    input  pipe_ctrl_pkg::wb_vec_t      wb_we_i,
    // commit
    input  logic                        commit_valid_i,
    input  logic                        commit_xcpt_i,
    input  logic                        commit_ecall_i,
    input  logic                        commit_fence_i,
    input  logic                        commit_fence_i_i,
    input  logic                        commit_csr_fence_i,
    input  logic                        commit_we_i,
    input  logic                        commit_regfile_we_i,
    input  logic                        commit_stall_i,
    // csr file, icache and debug module
    input  logic                        csr_stall_i,
    input  logic                        csr_eret_i,
    input  logic                        csr_exception_i,
    input  logic                        icache_miss_i,
    input  logic                        icache_ready_i,
    input  logic                        debug_halt_i,
    input  logic                        debug_change_pc_i,
    input  logic                        debug_wr_valid_i,
    // stall and flush levels
    output logic                        stall_if1_o,
    output logic                        stall_if2_o,
    output logic                        stall_id_o,
    output logic                        stall_ir_o,
    output logic                        stall_rr_o,
    output logic                        stall_exe_o,
    output logic                        flush_if_o,
    output logic                        flush_id_o,
    output logic                        flush_ir_o,
    output logic                        flush_rr_o,
    output logic                        flush_exe_o,
    // fetch control
    output pipe_ctrl_pkg::next_pc_sel_t next_pc_sel_o,
    output pipe_ctrl_pkg::sel_addr_if_t sel_addr_if_o,
    output logic                        invalidate_icache_o,
    output logic                        invalidate_buffer_o,
    // rename, commit and register file
    output logic                        do_checkpoint_o,
    output logic                        do_recover_o,
    output logic                        delete_checkpoint_o,
    output pipe_ctrl_pkg::chkp_t        recover_chkp_o,
    output logic                        enable_commit_update_o,
    output logic                        recover_commit_o,
    output logic                        flush_gl_o,
    output pipe_ctrl_pkg::gl_index_t    flush_gl_index_o,
    output logic                        flush_gl_commit_o,
    output logic                        enable_commit_o,
    output pipe_ctrl_pkg::wb_vec_t      rf_we_o,
    output logic                        rf_we_dbg_o
);

    ctrl_event_if ev (
        .clk_i  (clk_i),
        .rstn_i (rstn_i)
    );

    ctrl_event_decode u_decode (
        .ev (ev.decode_mp),
        .*
    );

    ctrl_hazard_resolve u_resolve (
        .ev (ev.resolve_mp),
        .*
    );

    // resolved levels feed back into the select and checkpoint logic
    ctrl_redirect_result u_result (
        .ev          (ev.result_mp),
        .stall_if1_i (stall_if1_o),
        .stall_ir_i  (stall_ir_o),
        .flush_ir_i  (flush_ir_o),
        .*
    );

endmodule

//--- testbench/tb_pipe_ctrl.sv
`timescale 1ns/1ps

module tb_pipe_ctrl;

    import pipe_ctrl_pkg::*;

    localparam int CLK_PERIOD      = 40;
    localparam int WATCHDOG_CYCLES = 2000;

    logic         clk_i = 1'b0;
    logic         rstn_i;
    logic         id_valid_i, id_is_branch_i, id_pred_branch_i, id_jal_i, id_csr_fence_i;
    logic         ir_valid_i, ir_is_branch_i, iq_full_i, free_list_empty_i, out_of_chkp_i;
    logic         gl_full_i, exe_valid_i, branch_correct_i, exe_stall_i, exe_chkp_done_i;
    chkp_t        exe_chkp_i;
    gl_index_t    exe_gl_index_i;
    wb_vec_t      wb_valid_i, wb_we_i;
    logic         commit_valid_i, commit_xcpt_i, commit_ecall_i, commit_fence_i;
    logic         commit_fence_i_i, commit_csr_fence_i, commit_we_i, commit_regfile_we_i;
    logic         commit_stall_i, csr_stall_i, csr_eret_i, csr_exception_i;
    logic         icache_miss_i, icache_ready_i, debug_halt_i, debug_change_pc_i;
    logic         debug_wr_valid_i;
    logic         stall_if1_o, stall_if2_o, stall_id_o, stall_ir_o, stall_rr_o, stall_exe_o;
    logic         flush_if_o, flush_id_o, flush_ir_o, flush_rr_o, flush_exe_o;
    next_pc_sel_t next_pc_sel_o;
    sel_addr_if_t sel_addr_if_o;
    logic         invalidate_icache_o, invalidate_buffer_o, do_checkpoint_o, do_recover_o;
    logic         delete_checkpoint_o, enable_commit_update_o, recover_commit_o, flush_gl_o;
    logic         flush_gl_commit_o, enable_commit_o, rf_we_dbg_o;
    chkp_t        recover_chkp_o;
    gl_index_t    flush_gl_index_o;
    wb_vec_t      rf_we_o;
    logic [31:0]  lfsr_state = 32'hec707959;

    // stall bits run from if1 down to exe and flush bits from if down to exe
    wire [5:0] stalls  = {stall_if1_o, stall_if2_o, stall_id_o,
                          stall_ir_o, stall_rr_o, stall_exe_o};
    wire [4:0] flushes = {flush_if_o, flush_id_o, flush_ir_o, flush_rr_o, flush_exe_o};

    pipe_ctrl_top uut (.*);

    always #(CLK_PERIOD / 2) clk_i = ~clk_i;

    task automatic check_value(input string name, input logic [31:0] got, input logic [31:0] exp);
        if (got !== exp) begin
            $display("[FAIL] %0t ns %s: got %0h, expected %0h", $time, name, got, exp);
            $display("CHECKS FAILED");
            $fatal(1, "value mismatch");
        end
    endtask

    function automatic logic [31:0] lfsr_step(input logic [31:0] s);
        // taps 32 22 2 1
        return {s[30:0], s[31] ^ s[21] ^ s[1] ^ s[0]};
    endfunction

    task automatic take_bits(input int n, output logic [31:0] v);
        v = '0;
        for (int i = 0; i < n; i++) begin
            lfsr_state = lfsr_step(lfsr_state);
            v = {v[30:0], lfsr_state[0]};
        end
    endtask

    // quiet pipeline with a ready icache
    task automatic set_idle;
        {id_valid_i, id_is_branch_i, id_pred_branch_i, id_jal_i, id_csr_fence_i} = '0;
        {ir_valid_i, ir_is_branch_i, iq_full_i, free_list_empty_i, out_of_chkp_i} = '0;
        {gl_full_i, exe_valid_i, branch_correct_i, exe_stall_i, exe_chkp_done_i} = '0;
        exe_chkp_i     = '0;
        exe_gl_index_i = '0;
        wb_valid_i     = '0;
        wb_we_i        = '0;
        {commit_valid_i, commit_xcpt_i, commit_ecall_i, commit_fence_i, commit_fence_i_i} = '0;
        {commit_csr_fence_i, commit_we_i, commit_regfile_we_i, commit_stall_i} = '0;
        {csr_stall_i, csr_eret_i, csr_exception_i, icache_miss_i} = '0;
        {debug_halt_i, debug_change_pc_i, debug_wr_valid_i} = '0;
        icache_ready_i = 1'b1;
    endtask

    task automatic settle;
        #(CLK_PERIOD / 4);
    endtask

    task automatic stage_levels(input logic [5:0] exp_stall, input logic [4:0] exp_flush);
        check_value("stall_if1/if2/id/ir/rr/exe", 32'(stalls), 32'(exp_stall));
        check_value("flush_if/id/ir/rr/exe", 32'(flushes), 32'(exp_flush));
    endtask

    task automatic fetch_selects(input next_pc_sel_t pc, input sel_addr_if_t addr);
        check_value("next_pc_sel", 32'(next_pc_sel_o), 32'(pc));
        check_value("sel_addr_if", 32'(sel_addr_if_o), 32'(addr));
    endtask

    task automatic idle_outputs;
        @(negedge clk_i);
        set_idle();
        settle();
        stage_levels(6'b0, 5'b0);
        fetch_selects(NEXT_PC_SEL_BP_OR_PC_4, SEL_JUMP_DECODE);
        check_value("invalidate_icache/buffer",
                    32'({invalidate_icache_o, invalidate_buffer_o}), 0);
        check_value("do_checkpoint/do_recover/delete_checkpoint",
                    32'({do_checkpoint_o, do_recover_o, delete_checkpoint_o}), 0);
        check_value("enable_commit", 32'(enable_commit_o), 1);
    endtask

    task automatic mispredict_recovery;
        logic [31:0] chkp;
        logic [31:0] idx;
        take_bits($bits(chkp_t), chkp);
        take_bits($bits(gl_index_t), idx);
        @(negedge clk_i);
        exe_valid_i     = 1'b1;
        exe_chkp_done_i = 1'b1;
        exe_chkp_i      = chkp_t'(chkp);
        exe_gl_index_i  = gl_index_t'(idx);
        // a rename branch must not take a checkpoint while ir is flushed
        ir_valid_i      = 1'b1;
        ir_is_branch_i  = 1'b1;
        settle();
        stage_levels(6'b000000, 5'b11110);
        fetch_selects(NEXT_PC_SEL_JUMP, SEL_JUMP_EXECUTION);
        check_value("do_recover", 32'(do_recover_o), 1);
        check_value("recover_chkp", 32'(recover_chkp_o), chkp);
        check_value("flush_gl", 32'(flush_gl_o), 1);
        check_value("flush_gl_index", 32'(flush_gl_index_o), idx);
        check_value("do_checkpoint", 32'(do_checkpoint_o), 0);
        @(negedge clk_i);
        exe_stall_i = 1'b1;
        settle();
        stage_levels(6'b000110, 5'b11100);
        @(negedge clk_i);
        exe_stall_i      = 1'b0;
        branch_correct_i = 1'b1;
        settle();
        stage_levels(6'b0, 5'b0);
        fetch_selects(NEXT_PC_SEL_BP_OR_PC_4, SEL_JUMP_DECODE);
        check_value("delete_checkpoint", 32'(delete_checkpoint_o), 1);
        check_value("do_recover", 32'(do_recover_o), 0);
        check_value("flush_gl_index", 32'(flush_gl_index_o), 0);
        check_value("do_checkpoint", 32'(do_checkpoint_o), 1);
    endtask

    task automatic exception_redirect;
        @(negedge clk_i);
        set_idle();
        commit_valid_i = 1'b1;
        commit_xcpt_i  = 1'b1;
        settle();
        check_value("enable_commit", 32'(enable_commit_o), 0);
        check_value("recover_commit", 32'(recover_commit_o), 0);
        @(negedge clk_i);
        settle();
        stage_levels(6'b0, 5'b11111);
        fetch_selects(NEXT_PC_SEL_JUMP, SEL_JUMP_CSR);
        check_value("recover_commit/flush_gl_commit",
                    32'({recover_commit_o, flush_gl_commit_o}), 3);
        check_value("invalidate_buffer", 32'(invalidate_buffer_o), 1);
        check_value("enable_commit", 32'(enable_commit_o), 0);
        // one-shot falls back even though the trigger is still high
        @(negedge clk_i);
        settle();
        check_value("recover_commit", 32'(recover_commit_o), 0);
        stage_levels(6'b0, 5'b0);
        @(negedge clk_i);
        commit_valid_i = 1'b0;
        commit_xcpt_i  = 1'b0;
        settle();
        check_value("recover_commit", 32'(recover_commit_o), 1);
        check_value("enable_commit", 32'(enable_commit_o), 1);
        check_value("invalidate_buffer", 32'(invalidate_buffer_o), 0);
        @(negedge clk_i);
        settle();
        check_value("recover_commit", 32'(recover_commit_o), 0);
    endtask

    // request bits from the msb down
    // csr_stall iq_full icache_miss exe_stall gl_full free_list_empty out_of_chkp
    function automatic logic [5:0] expected_stalls(input logic [6:0] req);
        logic [2:0] fe;
        logic [2:0] be;
        fe = (req[6] || req[5]) ? 3'b111 : (req[4] ? 3'b100 : 3'b000);
        be = req[6] ? 3'b111 : (req[3] || req[2]) ? 3'b110 :
             (req[1] || req[0]) ? 3'b100 : 3'b000;
        return {fe, be};
    endfunction

    task automatic apply_stalls(input logic [6:0] req);
        @(negedge clk_i);
        {csr_stall_i, iq_full_i, icache_miss_i, exe_stall_i, gl_full_i, free_list_empty_i,
         out_of_chkp_i} = req;
        settle();
        stage_levels(expected_stalls(req), {3'b000, req[2], 1'b0});
    endtask

    task automatic stall_priorities;
        @(negedge clk_i);
        set_idle();
        for (int i = 0; i < 7; i++) begin
            for (int j = i; j < 7; j++) begin
                apply_stalls(7'(1 << i) | 7'(1 << j));
            end
        end
        apply_stalls(7'b0);
    endtask

    task automatic csr_fence_hold;
        @(negedge clk_i);
        set_idle();
        id_valid_i     = 1'b1;
        id_csr_fence_i = 1'b1;
        settle();
        fetch_selects(NEXT_PC_SEL_KEEP_PC, SEL_JUMP_DECODE);
        stage_levels(6'b0, 5'b10000);
        repeat (3) begin
            @(negedge clk_i);
            id_valid_i     = 1'b0;
            id_csr_fence_i = 1'b0;
            settle();
            fetch_selects(NEXT_PC_SEL_KEEP_PC, SEL_JUMP_DECODE);
            stage_levels(6'b0, 5'b10000);
        end
        @(negedge clk_i);
        commit_valid_i     = 1'b1;
        commit_csr_fence_i = 1'b1;
        settle();
        stage_levels(6'b100000, 5'b10000);
        fetch_selects(NEXT_PC_SEL_KEEP_PC, SEL_JUMP_DECODE);
        check_value("invalidate_buffer", 32'(invalidate_buffer_o), 1);
        @(negedge clk_i);
        commit_valid_i     = 1'b0;
        commit_csr_fence_i = 1'b0;
        settle();
        fetch_selects(NEXT_PC_SEL_JUMP, SEL_JUMP_CSR_RW);
        stage_levels(6'b0, 5'b11000);
        @(negedge clk_i);
        settle();
        fetch_selects(NEXT_PC_SEL_BP_OR_PC_4, SEL_JUMP_DECODE);
        stage_levels(6'b0, 5'b0);
    endtask

    task automatic writeback_and_debug;
        @(negedge clk_i);
        set_idle();
        commit_valid_i      = 1'b1;
        commit_we_i         = 1'b1;
        commit_regfile_we_i = 1'b1;
        settle();
        check_value("rf_we", 32'(rf_we_o), 1);
        check_value("enable_commit_update", 32'(enable_commit_update_o), 1);
        @(negedge clk_i);
        set_idle();
        wb_valid_i = 2'b10;
        wb_we_i    = 2'b10;
        settle();
        check_value("rf_we", 32'(rf_we_o), 2);
        @(negedge clk_i);
        wb_valid_i = 2'b11;
        wb_we_i    = 2'b01;
        settle();
        check_value("rf_we", 32'(rf_we_o), 1);
        @(negedge clk_i);
        set_idle();
        debug_wr_valid_i = 1'b1;
        settle();
        check_value("rf_we_dbg", 32'(rf_we_dbg_o), 0);
        @(negedge clk_i);
        debug_halt_i = 1'b1;
        settle();
        check_value("rf_we_dbg", 32'(rf_we_dbg_o), 1);
        fetch_selects(NEXT_PC_SEL_KEEP_PC, SEL_JUMP_DECODE);
        // halt alone gives no debugger write
        @(negedge clk_i);
        debug_wr_valid_i  = 1'b0;
        debug_change_pc_i = 1'b1;
        settle();
        check_value("rf_we_dbg", 32'(rf_we_dbg_o), 0);
        fetch_selects(NEXT_PC_SEL_DEBUG, SEL_JUMP_DEBUG);
        @(negedge clk_i);
        set_idle();
        commit_valid_i   = 1'b1;
        commit_fence_i_i = 1'b1;
        settle();
        check_value("invalidate_icache/buffer",
                    32'({invalidate_icache_o, invalidate_buffer_o}), 3);
        // csr exception blocks the commit write and redirects next cycle
        @(negedge clk_i);
        set_idle();
        commit_valid_i  = 1'b1;
        commit_we_i     = 1'b1;
        csr_exception_i = 1'b1;
        settle();
        check_value("rf_we", 32'(rf_we_o), 0);
        check_value("enable_commit", 32'(enable_commit_o), 0);
        @(negedge clk_i);
        set_idle();
        settle();
        check_value("recover_commit", 32'(recover_commit_o), 1);
        @(negedge clk_i);
        settle();
        check_value("recover_commit", 32'(recover_commit_o), 0);
    endtask

    initial begin
        rstn_i = 1'b0;
        set_idle();
        repeat (10) @(posedge clk_i);
        @(negedge clk_i);
        rstn_i = 1'b1;
        idle_outputs();
        mispredict_recovery();
        exception_redirect();
        stall_priorities();
        csr_fence_hold();
        writeback_and_debug();
        $display("ALL CHECKS PASSED");
        $finish;
    end

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: tests did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("CHECKS FAILED");
        $fatal(1, "watchdog expired");
    end

endmodule

//--- vlog.f
+incdir+design
design/pipe_ctrl_pkg.sv
design/ctrl_event_if.sv
design/ctrl_event_decode.sv
design/ctrl_hazard_resolve.sv
design/ctrl_redirect_result.sv
design/pipe_ctrl_top.sv
testbench/tb_pipe_ctrl.sv

//--- run.sh
#!/bin/sh
# build and run the pipeline control testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log

verilator --binary --timing --assert -f vlog.f --top-module tb_pipe_ctrl -Mdir obj_dir
if [ $? -ne 0 ]; then
    echo "verilator build failed"
    exit 1
fi

./obj_dir/Vtb_pipe_ctrl > "$LOG" 2>&1
status=$?
cat "$LOG"
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "ALL CHECKS PASSED" "$LOG"; then
    exit 0
fi
echo "pass message not found in $LOG"
exit 1
